//--- all.f
logic/icache_geom_pkg.sv
logic/icache_refill_pkg.sv
logic/icache_lookup_if.sv
logic/icache_fill_if.sv
logic/icache_addr_decode.sv
logic/icache_tag_array.sv
logic/icache_refill_ctrl.sv
logic/icache_top.sv
bench/icache_mem_model.sv
bench/icache_tb.sv

//--- bench/icache_mem_model.sv
`default_nettype none

module icache_mem_model #(
    parameter int unsigned seed = 32'h8c7e
) (
    input  wire         Clk,
    input  wire         rst_n,
    input  wire  [31:0] mem_read_address,
    input  wire         mem_read_request,
    output logic [31:0] mem_data_in,
    output logic        mem_data_ready
);

    logic        seeded;
    logic        in_burst;
    int unsigned beat;
    int unsigned gap;

    // Memory contents follow the word address
    function automatic logic [31:0] word_at(input logic [31:0] word_addr);
        return word_addr ^ 32'h5a5a0000;
    endfunction

    initial begin
        seeded         = 1'b0;
        in_burst       = 1'b0;
        beat           = 0;
        gap            = 0;
        mem_data_in    = '0;
        mem_data_ready = 1'b0;
    end

    // Outputs move on the falling edge, the DUT samples on the rising one
    always @(negedge Clk) begin
        if (!seeded) begin
            void'($urandom(seed));
            seeded = 1'b1;
        end
        if (!rst_n || !mem_read_request) begin
            in_burst       = 1'b0;
            mem_data_ready = 1'b0;
        end else begin
            if (!in_burst) begin
                in_burst = 1'b1;
                beat     = 0;
                gap      = $urandom % 4;
            end
            if (beat >= 4) begin
                // Whole block sent, request is about to drop
                mem_data_ready = 1'b0;
            end else if (gap > 0) begin
                mem_data_ready = 1'b0;
                gap            = gap - 1;
            end else begin
                mem_data_ready = 1'b1;
                mem_data_in    = word_at((mem_read_address >> 2) + beat);
                beat           = beat + 1;
                gap            = $urandom % 4;
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/icache_tb.sv
`default_nettype none

module icache_tb;

    localparam int num_tests           = 6;
    localparam int wait_limit          = 100;
    localparam int unsigned mem_seed   = 32'h8c7e;

    logic        Clk;
    logic        rst_n;
    logic        read_enable;
    logic [31:0] read_address;
    logic        mispredict;
    wire  [31:0] instruction;
    wire         ready;
    wire         busy;
    wire  [31:0] mem_read_address;
    wire         mem_read_request;
    wire  [31:0] mem_data_in;
    wire         mem_data_ready;

    int          error_count;
    int unsigned edge_count;
    int unsigned beat_count;
    logic        req_prev;
    int unsigned accept_edges[$];
    int unsigned resp_edges[$];
    logic [31:0] resp_words[$];
    logic [31:0] req_addrs[$];

    icache_top dut (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .read_enable      (read_enable),
        .read_address     (read_address),
        .mispredict       (mispredict),
        .instruction      (instruction),
        .ready            (ready),
        .busy             (busy),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    icache_mem_model #(.seed(mem_seed)) memory (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready)
    );

    always #20 Clk = ~Clk;

    // Handshake log, sampled on the DUT's own edge
    always @(posedge Clk) begin
        if (rst_n) begin
            if (read_enable && !busy) begin
                accept_edges.push_back(edge_count);
            end
            if (ready) begin
                resp_edges.push_back(edge_count);
                resp_words.push_back(instruction);
            end
            if (mem_read_request && !req_prev) begin
                req_addrs.push_back(mem_read_address);
            end
            if (mem_read_request && mem_data_ready) begin
                beat_count = beat_count + 1;
            end
        end
        req_prev   = mem_read_request;
        edge_count = edge_count + 1;
    end

    // Byte address to the word memory holds there
    function automatic logic [31:0] expected_word(input logic [31:0] byte_addr);
        return (byte_addr >> 2) ^ 32'h5a5a0000;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic report_stuck(input string what);
        $display("Gave up at %0t after %0d cycles waiting for %s", $time, wait_limit, what);
        error_count++;
    endtask

    task automatic clear_log();
        accept_edges.delete();
        resp_edges.delete();
        resp_words.delete();
        req_addrs.delete();
        beat_count = 0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (3) @(negedge Clk);
        rst_n = 1'b1;
    endtask

    // Holds the request until the cache takes it
    task automatic start_fetch(input logic [31:0] addr);
        int n;
        int waited;
        n            = accept_edges.size();
        waited       = 0;
        read_enable  = 1'b1;
        read_address = addr;
        do begin
            @(negedge Clk);
            waited++;
        end while (accept_edges.size() == n && waited < wait_limit);
        read_enable = 1'b0;
        if (accept_edges.size() == n) begin
            report_stuck("the request to be accepted");
        end
    endtask

    task automatic wait_responses(input int n);
        int waited;
        waited = 0;
        while (resp_edges.size() < n && waited < wait_limit) begin
            @(negedge Clk);
            waited++;
        end
        if (resp_edges.size() < n) begin
            report_stuck("ready");
        end
    endtask

    task automatic fetch_checked(input logic [31:0] addr, input logic expect_miss);
        clear_log();
        start_fetch(addr);
        wait_responses(1);
        if (resp_edges.size() > 0 && accept_edges.size() > 0) begin
            check_value(resp_words[0], expected_word(addr), "fetched word");
            if (expect_miss) begin
                check_value(req_addrs.size(), 1, "memory requests for a miss");
                if (req_addrs.size() > 0) begin
                    check_value(req_addrs[0], {addr[31:4], 4'h0}, "memory block address");
                end
            end else begin
                check_value(req_addrs.size(), 0, "memory requests for a hit");
                check_value(resp_edges[0] - accept_edges[0] - 1, 2, "hit latency");
            end
        end
    endtask

    task automatic miss_then_hit();
        fetch_checked(32'h0000_1204, 1'b1);
        fetch_checked(32'h0000_1208, 1'b0);
    endtask

    task automatic back_to_back_hits();
        logic [31:0] base;
        int          i;
        base = 32'h0000_2010;
        fetch_checked(base, 1'b1);
        clear_log();
        read_enable = 1'b1;
        for (i = 0; i < 4; i++) begin
            read_address = base + 4 * i;
            @(negedge Clk);
        end
        read_enable = 1'b0;
        wait_responses(4);
        check_value(accept_edges.size(), 4, "accepted back-to-back requests");
        check_value(req_addrs.size(), 0, "memory requests for back-to-back hits");
        for (i = 0; i < 4 && i < resp_edges.size(); i++) begin
            check_value(resp_words[i], expected_word(base + 4 * i), "back-to-back word");
            check_value(resp_edges[i], resp_edges[0] + i, "back-to-back ready cycle");
        end
    endtask

    // Five blocks in set 3, tags 0x10 to 0x14
    task automatic round_robin_replace();
        logic [31:0] blocks[5];
        int          i;
        for (i = 0; i < 5; i++) begin
            blocks[i] = 32'h0000_0830 + 32'h80 * i;
            fetch_checked(blocks[i], 1'b1);
        end
        for (i = 1; i < 5; i++) begin
            fetch_checked(blocks[i] + 4, 1'b0);
        end
        // Way 0 went to the fifth block
        fetch_checked(blocks[0] + 8, 1'b1);
    endtask

    task automatic held_behind_miss();
        logic [31:0] miss_addr;
        logic [31:0] held_addr;
        int          waited;
        miss_addr = 32'h0000_3020;
        held_addr = 32'h0000_302c;
        waited    = 0;
        clear_log();
        start_fetch(miss_addr);
        while (!busy && waited < wait_limit) begin
            @(negedge Clk);
            waited++;
        end
        if (!busy) begin
            report_stuck("busy after a miss");
        end
        start_fetch(held_addr);
        wait_responses(2);
        check_value(req_addrs.size(), 1, "memory requests with a held request");
        if (resp_edges.size() == 2 && accept_edges.size() == 2) begin
            check_value(resp_words[0], expected_word(miss_addr), "missed word");
            check_value(resp_words[1], expected_word(held_addr), "held word");
            check_value(accept_edges[1] >= resp_edges[0], 1, "held request taken after fill");
        end
    endtask

    task automatic mispredict_cancel();
        logic [31:0] cancel_addr;
        int          waited;
        cancel_addr = 32'h0000_4044;
        waited      = 0;
        clear_log();
        start_fetch(cancel_addr);
        while (beat_count == 0 && waited < wait_limit) begin
            @(negedge Clk);
            waited++;
        end
        if (beat_count == 0) begin
            report_stuck("the first refill beat");
        end
        mispredict = 1'b1;
        @(negedge Clk);
        mispredict = 1'b0;
        check_value(mem_read_request, 1'b0, "memory request after mispredict");
        // Nothing may answer the cancelled fetch in this quiet period
        repeat (20) @(negedge Clk);
        check_value(resp_edges.size(), 0, "ready pulses after cancel");
        check_value(busy, 1'b0, "busy after cancel");
        fetch_checked(cancel_addr, 1'b1);
    endtask

    task automatic reset_clears_state();
        fetch_checked(32'h0000_1204, 1'b0);
        rst_n = 1'b0;
        repeat (3) @(negedge Clk);
        check_value({ready, busy, mem_read_request}, 3'b000, "outputs in reset");
        rst_n = 1'b1;
        @(negedge Clk);
        check_value({ready, busy, mem_read_request}, 3'b000, "outputs after reset");
        fetch_checked(32'h0000_1204, 1'b1);
    endtask

    initial begin
        Clk          = 1'b0;
        rst_n        = 1'b0;
        read_enable  = 1'b0;
        read_address = '0;
        mispredict   = 1'b0;
        error_count  = 0;
        edge_count   = 0;
        beat_count   = 0;
        req_prev     = 1'b0;
        apply_reset();
        miss_then_hit();
        back_to_back_hits();
        round_robin_replace();
        held_behind_miss();
        mispredict_cancel();
        reset_clears_state();
        $display("Errors counted: %0d", error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit scales with the number of tests
    initial begin
        repeat (num_tests * 400 + 200) @(posedge Clk);
        $display("Run did not complete within %0d clock periods, errors counted: %0d",
                 num_tests * 400 + 200, error_count);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/icache_addr_decode.sv
`default_nettype none

module icache_addr_decode (
    input  wire         Clk,
    input  wire         rst_n,
    input  wire         read_enable,
    input  wire  [31:0] read_address,
    input  wire         mispredict,
    output logic        busy,
    icache_lookup_if.decode_mp lookup
);
    import icache_geom_pkg::*;

    fetch_addr_u addr_q;
    logic        valid_q;
    logic        accept;

    // One back-pressure signal toward the core
    assign busy   = lookup.stall;
    assign accept = read_enable && !lookup.stall;

    // Lookup slot stays put while execute stalls
    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (mispredict) begin
            // Flush whatever is waiting in the lookup stage
            valid_q <= 1'b0;
        end else if (!lookup.stall) begin
            valid_q <= read_enable;
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) begin
            addr_q.raw <= read_address;
        end
    end

    assign lookup.lookup_valid = valid_q;
    assign lookup.lookup_addr  = addr_q;

endmodule

`default_nettype wire

//--- logic/icache_fill_if.sv
`default_nettype none

interface icache_fill_if;
    import icache_geom_pkg::*;
    import icache_refill_pkg::*;

    // Execute to result
    logic        miss_valid;
    fetch_addr_u miss_addr;
    logic        hit_valid;
    logic [31:0] hit_word;

    // Result to execute
    logic                         fill_write;
    fetch_addr_u                  fill_addr;
    logic [block_words-1:0][31:0] fill_block;
    refill_state_e                refill_state;
    logic                         refill_busy;

    // Any state other than idle holds the lookup stage
    assign refill_busy = (refill_state != idle);

    modport lookup_mp (
        output miss_valid, miss_addr, hit_valid, hit_word,
        input  fill_write, fill_addr, fill_block, refill_busy
    );

    modport refill_mp (
        input  miss_valid, miss_addr, hit_valid, hit_word,
        output fill_write, fill_addr, fill_block, refill_state
    );

endinterface

`default_nettype wire

//--- logic/icache_geom_pkg.sv
`default_nettype none

package icache_geom_pkg;

    // Cache shape
    localparam int num_sets    = 8;
    localparam int num_ways    = 4;
    localparam int block_words = 4;

    // Field widths of a 32-bit byte address
    localparam int set_bits  = $clog2(num_sets);
    localparam int way_bits  = $clog2(num_ways);
    localparam int word_bits = $clog2(block_words);
    localparam int tag_bits  = 32 - set_bits - word_bits - 2;

    // Fetch address, seen either as a plain byte address
    // or split into the fields the cache indexes with
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_bits-1:0]  tag;
            logic [set_bits-1:0]  set;
            logic [word_bits-1:0] word;
            logic [1:0]           byte_sel;
        } fld;
    } fetch_addr_u;

endpackage

`default_nettype wire

//--- logic/icache_lookup_if.sv
`default_nettype none

interface icache_lookup_if;
    import icache_geom_pkg::*;

    // Registered lookup from decode
    logic        lookup_valid;
    fetch_addr_u lookup_addr;

    // Back-pressure from execute
    logic        stall;

    modport decode_mp (
        output lookup_valid,
        output lookup_addr,
        input  stall
    );

    modport execute_mp (
        input  lookup_valid,
        input  lookup_addr,
        output stall
    );

endinterface

`default_nettype wire

//--- logic/icache_refill_ctrl.sv
`default_nettype none

module icache_refill_ctrl (
    input  wire         Clk,
    input  wire         rst_n,
    input  wire         mispredict,
    input  wire  [31:0] mem_data_in,
    input  wire         mem_data_ready,
    output logic [31:0] instruction,
    output logic        ready,
    output logic [31:0] mem_read_address,
    output logic        mem_read_request,
    icache_fill_if.refill_mp fill
);
    import icache_geom_pkg::*;
    import icache_refill_pkg::*;

    refill_state_e                state;
    logic [beat_count_bits-1:0]   beat_cnt;
    fetch_addr_u                  miss_q;
    fetch_addr_u                  block_base;
    logic [block_words-1:0][31:0] beats;
    logic [block_words-1:0][31:0] beats_next;
    logic [31:0]                  resp_word;
    logic                         collecting;
    logic                         take_beat;
    logic                         last_beat;
    logic                         start;

    // Block-aligned form of the missing address
    always_comb begin
        block_base              = fill.miss_addr;
        block_base.fld.word     = '0;
        block_base.fld.byte_sel = '0;
    end

    assign collecting = (state == request) || (state == collect);
    assign take_beat  = collecting && mem_data_ready && !mispredict;
    assign last_beat  = take_beat && (beat_cnt == beat_count_bits'(block_words - 1));
    assign start      = (state == idle) && fill.miss_valid && !mispredict;

    // Incoming beat merged in, so the last word can be answered at once
    always_comb begin
        beats_next           = beats;
        beats_next[beat_cnt] = mem_data_in;
        resp_word            = beats_next[miss_q.fld.word];
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            state            <= idle;
            beat_cnt         <= '0;
            mem_read_request <= 1'b0;
            ready            <= 1'b0;
            fill.fill_write  <= 1'b0;
        end else begin
            ready           <= fill.hit_valid || last_beat;
            fill.fill_write <= last_beat;
            case (state)
                idle: begin
                    if (start) begin
                        state            <= request;
                        beat_cnt         <= '0;
                        mem_read_request <= 1'b1;
                    end
                end
                request, collect: begin
                    if (mispredict) begin
                        // Cancel writes nothing and gives no answer
                        state            <= idle;
                        mem_read_request <= 1'b0;
                    end else if (take_beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            state            <= respond;
                            mem_read_request <= 1'b0;
                        end else begin
                            state <= collect;
                        end
                    end
                end
                respond: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (start) begin
            miss_q           <= fill.miss_addr;
            mem_read_address <= block_base.raw;
        end
        if (take_beat) begin
            beats <= beats_next;
        end
        if (last_beat) begin
            instruction <= resp_word;
        end else if (fill.hit_valid) begin
            instruction <= fill.hit_word;
        end
    end

    assign fill.fill_addr    = miss_q;
    assign fill.fill_block   = beats;
    assign fill.refill_state = state;

    // Memory sees a steady address for the whole burst
    a_addr_stable: assert property (@(posedge Clk) disable iff (!rst_n)
        mem_read_request && $past(mem_read_request) |-> $stable(mem_read_address));

endmodule

`default_nettype wire

//--- logic/icache_refill_pkg.sv
`default_nettype none

package icache_refill_pkg;

    // One beat per word of a block
    localparam int beat_count_bits = $clog2(icache_geom_pkg::block_words);

    // Refill sequence
    // request waits for the first beat, collect gathers the rest,
    // respond is the single cycle in which the block is written
    typedef enum logic [1:0] {
        idle,
        request,
        collect,
        respond
    } refill_state_e;

endpackage

`default_nettype wire

//--- logic/icache_tag_array.sv
`default_nettype none

module icache_tag_array (
    input wire Clk,
    input wire rst_n,
    icache_lookup_if.execute_mp lookup,
    icache_fill_if.lookup_mp    fill
);
    import icache_geom_pkg::*;

    // Storage
    logic [tag_bits-1:0] tags  [num_sets][num_ways];
    logic [num_ways-1:0] valid [num_sets];
    logic [31:0]         data  [num_sets][num_ways][block_words];
    logic [way_bits-1:0] rr_ptr [num_sets];

    logic [num_ways-1:0] way_match;
    logic [way_bits-1:0] hit_way;
    logic                active;
    logic                hit_any;
    logic [set_bits-1:0] look_set;
    logic [set_bits-1:0] fill_set;
    logic [way_bits-1:0] victim;
    logic                set_full;

    // No lookups are resolved while a refill owns the cache
    assign active   = lookup.lookup_valid && !fill.refill_busy;
    assign look_set = lookup.lookup_addr.fld.set;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            way_match[w] = valid[look_set][w] &&
                           (tags[look_set][w] == lookup.lookup_addr.fld.tag);
            if (way_match[w]) begin
                hit_way = way_bits'(w);
            end
        end
    end

    assign hit_any = active && (|way_match);

    // Miss drops after one cycle since refill_busy rises behind it
    assign fill.miss_valid = active && !(|way_match);
    assign fill.miss_addr  = lookup.lookup_addr;
    assign lookup.stall    = fill.refill_busy;

    // Victim is the lowest invalid way, else the round-robin pointer
    assign fill_set = fill.fill_addr.fld.set;
    assign set_full = &valid[fill_set];

    always_comb begin
        victim = rr_ptr[fill_set];
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid[fill_set][w]) begin
                victim = way_bits'(w);
            end
        end
    end

    always_ff @(posedge Clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
            fill.hit_valid <= 1'b0;
        end else begin
            fill.hit_valid <= hit_any;
            if (fill.fill_write) begin
                valid[fill_set][victim] <= 1'b1;
                // Pointer only moves when it actually chose the victim
                if (set_full) begin
                    rr_ptr[fill_set] <= rr_ptr[fill_set] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (hit_any) begin
            fill.hit_word <= data[look_set][hit_way][lookup.lookup_addr.fld.word];
        end
        if (fill.fill_write) begin
            tags[fill_set][victim] <= fill.fill_addr.fld.tag;
            for (int k = 0; k < block_words; k++) begin
                data[fill_set][victim][k] <= fill.fill_block[k];
            end
        end
    end

    // A block is never present in two ways of a set
    a_one_way_match: assert property (@(posedge Clk) disable iff (!rst_n)
        lookup.lookup_valid |-> $onehot0(way_match));

endmodule

`default_nettype wire

//--- logic/icache_top.sv
`default_nettype none

module icache_top (
    input  wire         Clk,
    input  wire         rst_n,
    // Core side
    input  wire         read_enable,
    input  wire  [31:0] read_address,
    input  wire         mispredict,
    output logic [31:0] instruction,
    output logic        ready,
    output logic        busy,
    // Memory side
    output logic [31:0] mem_read_address,
    output logic        mem_read_request,
    input  wire  [31:0] mem_data_in,
    input  wire         mem_data_ready
);

    icache_lookup_if lookup_bus ();
    icache_fill_if   fill_bus ();

    icache_addr_decode u_decode (
        .Clk          (Clk),
        .rst_n        (rst_n),
        .read_enable  (read_enable),
        .read_address (read_address),
        .mispredict   (mispredict),
        .busy         (busy),
        .lookup       (lookup_bus.decode_mp)
    );

    icache_tag_array u_execute (
        .Clk    (Clk),
        .rst_n  (rst_n),
        .lookup (lookup_bus.execute_mp),
        .fill   (fill_bus.lookup_mp)
    );

    icache_refill_ctrl u_result (
        .Clk              (Clk),
        .rst_n            (rst_n),
        .mispredict       (mispredict),
        .mem_data_in      (mem_data_in),
        .mem_data_ready   (mem_data_ready),
        .instruction      (instruction),
        .ready            (ready),
        .mem_read_address (mem_read_address),
        .mem_read_request (mem_read_request),
        .fill             (fill_bus.refill_mp)
    );

endmodule

`default_nettype wire
